// File: design/drive_combine.sv
`timescale 1ns/1ps
`default_nettype none

module drive_combine (
	input wire clk,
	input wire arst_n,
	input wire fdbk_pkg::iq_pair_t drive,
	input wire fdbk_pkg::sample_t prop_xy,
	input wire prop_iq,
	output fdbk_pkg::sample_t out_xy,
	output logic out_iq
);

	import fdbk_pkg::*;

	sample_t drv_sel;
	// One bit of growth for the sum
	err_t sum;

	always_comb begin
		// Held integral drive of the current axis
		drv_sel = prop_iq ? drive.i : drive.q;
		sum = drv_sel + prop_xy;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_xy <= '0;
			out_iq <= 1'b0;
		end else begin
			// Clip to full scale of the output word
			out_xy <= sat_sample(sum);
			out_iq <= prop_iq;
		end
	end

endmodule

`default_nettype wire

// File: design/fdbk_config.svh
`ifndef FDBK_CONFIG_SVH
`define FDBK_CONFIG_SVH

// Fixed widths and shifts of the feedback core

// Input and output baseband samples
`define FDBK_SAMPLE_W 18

// Decimator sums
// Four samples per axis plus headroom
`define FDBK_ACC_W 22

// Signed loop gains
`define FDBK_GAIN_W 16

// Right shift after every gain product
// Unity gain is 1 << 15
`define FDBK_GAIN_SHIFT 15

// Cycles per sync frame, I/Q interleaved
`define FDBK_FRAME 8

`endif

// File: design/fdbk_core.sv
`timescale 1ns/1ps
`default_nettype none

module fdbk_core (
	input wire clk,
	input wire arst_n,
	input wire sync,
	input wire iq,
	input wire fdbk_pkg::sample_t in_xy,
	input wire fdbk_pkg::fdbk_settings_t settings,
	input wire fdbk_pkg::shift_t coarse_scale,
	output fdbk_pkg::sample_t out_xy,
	output logic out_iq,
	output fdbk_pkg::cmp_event_t cmp_event
);

	import fdbk_pkg::*;

	// Slow path links
	iq_pair_t avg;
	logic avg_stb;
	iq_pair_t drive;
	// Fast path links
	sample_t prop_xy;
	logic prop_iq;

	// Frame averaging ahead of the integral loop
	frame_decim u_decim (
		.clk     (clk),
		.arst_n  (arst_n),
		.sync    (sync),
		.iq      (iq),
		.in_xy   (in_xy),
		.avg     (avg),
		.avg_stb (avg_stb)
	);

	// Integral path, one update per frame
	integ_ctrl u_integ (
		.clk       (clk),
		.arst_n    (arst_n),
		.avg       (avg),
		.avg_stb   (avg_stb),
		.settings  (settings),
		.drive     (drive),
		.cmp_event (cmp_event)
	);

	// Proportional path, every sample
	prop_ctrl u_prop (
		.clk          (clk),
		.arst_n       (arst_n),
		.iq           (iq),
		.in_xy        (in_xy),
		.settings     (settings),
		.coarse_scale (coarse_scale),
		.prop_xy      (prop_xy),
		.prop_iq      (prop_iq)
	);

	// Sum of both paths to the output
	drive_combine u_combine (
		.clk     (clk),
		.arst_n  (arst_n),
		.drive   (drive),
		.prop_xy (prop_xy),
		.prop_iq (prop_iq),
		.out_xy  (out_xy),
		.out_iq  (out_iq)
	);

endmodule

`default_nettype wire

// File: design/fdbk_pkg.sv
`default_nettype none

`include "fdbk_config.svh"

package fdbk_pkg;

	// Plain vector types
	typedef logic signed [`FDBK_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`FDBK_ACC_W-1:0] acc_t;
	typedef logic signed [`FDBK_GAIN_W-1:0] gain_t;
	typedef logic [1:0] shift_t;
	// Setpoint minus sample, one extra bit
	typedef logic signed [`FDBK_SAMPLE_W:0] err_t;
	// Full error times gain product
	typedef logic signed [`FDBK_SAMPLE_W+`FDBK_GAIN_W:0] prod_t;

	// Static loop settings
	typedef struct packed {
		sample_t set_x;
		sample_t set_y;
		gain_t gain_i;
		gain_t gain_p;
		sample_t lim_hi;
		sample_t lim_lo;
	} fdbk_settings_t;

	// Clamp events per axis
	typedef struct packed {
		logic x_hi;
		logic x_lo;
		logic y_hi;
		logic y_lo;
	} cmp_event_t;

	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_pair_t;

	typedef enum logic {
		DEC_IDLE,
		DEC_RUN
	} dec_state_t;

	// Saturate a wide signed value into one sample
	function automatic sample_t sat_sample(input prod_t v);
		logic [$bits(prod_t)-`FDBK_SAMPLE_W:0] top;
		top = v[$bits(prod_t)-1:`FDBK_SAMPLE_W-1];
		// All upper bits equal to the sign, so it fits
		if (&top || !(|top))
			return sample_t'(v);
		return v[$bits(prod_t)-1] ? {1'b1, {(`FDBK_SAMPLE_W-1){1'b0}}}
			: {1'b0, {(`FDBK_SAMPLE_W-1){1'b1}}};
	endfunction

endpackage

`default_nettype wire

// File: design/frame_decim.sv
`timescale 1ns/1ps
`default_nettype none

`include "fdbk_config.svh"

module frame_decim (
	input wire clk,
	input wire arst_n,
	input wire sync,
	input wire iq,
	input wire fdbk_pkg::sample_t in_xy,
	output fdbk_pkg::iq_pair_t avg,
	output logic avg_stb
);

	import fdbk_pkg::*;

	dec_state_t state;
	logic [$clog2(`FDBK_FRAME)-1:0] cnt;
	acc_t acc_i;
	acc_t acc_q;
	acc_t in_ext;
	acc_t base_i;
	acc_t base_q;
	acc_t nxt_i;
	acc_t nxt_q;
	logic frame_end;

	always_comb begin
		in_ext = acc_t'(in_xy);
		// Sync starts a fresh frame
		base_i = sync ? '0 : acc_i;
		base_q = sync ? '0 : acc_q;
		// Steer the sample to its axis
		nxt_i = iq ? base_i + in_ext : base_i;
		nxt_q = iq ? base_q : base_q + in_ext;
		// Eighth sample of a frame that began with a sync
		frame_end = (state == DEC_RUN) && !sync && (cnt == `FDBK_FRAME - 1);
	end

	// Frame tracking and strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DEC_IDLE;
			cnt <= '0;
			avg_stb <= 1'b0;
		end else begin
			avg_stb <= frame_end;
			case (state)
				DEC_IDLE: begin
					// Wait for the first frame boundary
					if (sync) begin
						state <= DEC_RUN;
						cnt <= 1;
					end
				end
				DEC_RUN: begin
					cnt <= sync ? 1 : cnt + 1'b1;
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// Sums and averaged pair
	always_ff @(posedge clk) begin
		acc_i <= nxt_i;
		acc_q <= nxt_q;
		if (frame_end) begin
			// Four samples per axis, floor divide by four
			avg.i <= sample_t'(nxt_i >>> ($clog2(`FDBK_FRAME) - 1));
			avg.q <= sample_t'(nxt_q >>> ($clog2(`FDBK_FRAME) - 1));
		end
	end

endmodule

`default_nettype wire

// File: design/integ_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fdbk_config.svh"

module integ_ctrl (
	input wire clk,
	input wire arst_n,
	input wire fdbk_pkg::iq_pair_t avg,
	input wire avg_stb,
	input wire fdbk_pkg::fdbk_settings_t settings,
	output fdbk_pkg::iq_pair_t drive,
	output fdbk_pkg::cmp_event_t cmp_event
);

	import fdbk_pkg::*;

	prod_t sum_i;
	prod_t sum_q;
	logic hi_i;
	logic lo_i;
	logic hi_q;
	logic lo_q;

	// Unclamped drive after one integral step
	function automatic prod_t integ_sum(
		input sample_t drv,
		input sample_t set,
		input sample_t avg_in,
		input gain_t gain
	);
		err_t err;
		prod_t prod;
		err = set - avg_in;
		prod = err * gain;
		return (prod >>> `FDBK_GAIN_SHIFT) + drv;
	endfunction

	// High limit wins if the limits cross
	function automatic sample_t clamp(input prod_t v, input sample_t hi, input sample_t lo);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return sample_t'(v);
	endfunction

	always_comb begin
		// X rides on I samples, Y on Q samples
		sum_i = integ_sum(drive.i, settings.set_x, avg.i, settings.gain_i);
		sum_q = integ_sum(drive.q, settings.set_y, avg.q, settings.gain_i);
		hi_i = sum_i > settings.lim_hi;
		lo_i = !hi_i && (sum_i < settings.lim_lo);
		hi_q = sum_q > settings.lim_hi;
		lo_q = !hi_q && (sum_q < settings.lim_lo);
	end

	// Drive holds between strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			drive <= '0;
			cmp_event <= '0;
		end else begin
			// Events are single-cycle pulses
			cmp_event <= '0;
			if (avg_stb) begin
				drive.i <= clamp(sum_i, settings.lim_hi, settings.lim_lo);
				drive.q <= clamp(sum_q, settings.lim_hi, settings.lim_lo);
				cmp_event.x_hi <= hi_i;
				cmp_event.x_lo <= lo_i;
				cmp_event.y_hi <= hi_q;
				cmp_event.y_lo <= lo_q;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/prop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fdbk_config.svh"

module prop_ctrl (
	input wire clk,
	input wire arst_n,
	input wire iq,
	input wire fdbk_pkg::sample_t in_xy,
	input wire fdbk_pkg::fdbk_settings_t settings,
	input wire fdbk_pkg::shift_t coarse_scale,
	output fdbk_pkg::sample_t prop_xy,
	output logic prop_iq
);

	import fdbk_pkg::*;

	sample_t set_sel;
	err_t err;
	prod_t prod;
	prod_t scaled;

	always_comb begin
		// Setpoint of this sample's axis
		set_sel = iq ? settings.set_x : settings.set_y;
		err = set_sel - in_xy;
		prod = err * settings.gain_p;
		// Coarse scale adds up to three more bits of attenuation
		scaled = prod >>> (`FDBK_GAIN_SHIFT + coarse_scale);
	end

	// One register stage for low latency
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prop_xy <= '0;
			prop_iq <= 1'b0;
		end else begin
			prop_xy <= sat_sample(scaled);
			// Axis flag travels with the term
			prop_iq <= iq;
		end
	end

endmodule

`default_nettype wire

// File: dv/fdbk_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fdbk_config.svh"

module fdbk_checker (
	input wire clk,
	input wire arst_n,
	input wire sync,
	input wire iq,
	input wire fdbk_pkg::sample_t in_xy,
	input wire fdbk_pkg::fdbk_settings_t settings,
	input wire fdbk_pkg::shift_t coarse_scale,
	input wire fdbk_pkg::sample_t out_xy,
	input wire out_iq,
	input wire fdbk_pkg::cmp_event_t cmp_event,
	output int err_cnt,
	output int check_cnt
);

	import fdbk_pkg::*;

	localparam longint SMAX = (longint'(1) <<< (`FDBK_SAMPLE_W - 1)) - 1;
	localparam longint SMIN = -(longint'(1) <<< (`FDBK_SAMPLE_W - 1));

	// Model state kept in plain integers
	longint m_sum_i;
	longint m_sum_q;
	longint m_avg_i;
	longint m_avg_q;
	longint m_drv_i;
	longint m_drv_q;
	longint m_prop;
	longint m_out;
	longint cur;
	int m_phase;
	logic m_seen;
	logic m_stb;
	logic m_prop_iq;
	logic m_out_iq;
	logic ev_hi;
	logic ev_lo;
	cmp_event_t m_ev;

	// Clip to the signed 18-bit range
	function automatic longint clip(input longint v);
		if (v > SMAX)
			return SMAX;
		if (v < SMIN)
			return SMIN;
		return v;
	endfunction

	// Expected proportional term of one sample
	function automatic longint prop_ref(input longint set, input longint x, input longint gain,
		input int cs);
		return clip(((set - x) * gain) >>> (`FDBK_GAIN_SHIFT + cs));
	endfunction

	// Expected integral drive after one frame, with clamp flags
	function automatic longint integ_ref(input longint drv, input longint set, input longint avg,
		input longint gain, input longint hi, input longint lo,
		output logic flag_hi, output logic flag_lo);
		longint sum;
		sum = drv + (((set - avg) * gain) >>> `FDBK_GAIN_SHIFT);
		flag_hi = 1'b0;
		flag_lo = 1'b0;
		if (sum > hi) begin
			flag_hi = 1'b1;
			return hi;
		end
		if (sum < lo) begin
			flag_lo = 1'b1;
			return lo;
		end
		return sum;
	endfunction

	// Stages are updated from the output back, so each uses the old upstream value
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			m_sum_i = 0;
			m_sum_q = 0;
			m_avg_i = 0;
			m_avg_q = 0;
			m_drv_i = 0;
			m_drv_q = 0;
			m_prop = 0;
			m_out = 0;
			m_phase = 0;
			m_seen = 1'b0;
			m_stb = 1'b0;
			m_prop_iq = 1'b0;
			m_out_iq = 1'b0;
			m_ev = '0;
		end else begin
			// Combiner uses the drive held before this edge
			m_out = clip((m_prop_iq ? m_drv_i : m_drv_q) + m_prop);
			m_out_iq = m_prop_iq;
			// Integral step one cycle after the strobe
			m_ev = '0;
			if (m_stb) begin
				m_drv_i = integ_ref(m_drv_i, settings.set_x, m_avg_i, settings.gain_i,
					settings.lim_hi, settings.lim_lo, ev_hi, ev_lo);
				m_ev.x_hi = ev_hi;
				m_ev.x_lo = ev_lo;
				m_drv_q = integ_ref(m_drv_q, settings.set_y, m_avg_q, settings.gain_i,
					settings.lim_hi, settings.lim_lo, ev_hi, ev_lo);
				m_ev.y_hi = ev_hi;
				m_ev.y_lo = ev_lo;
			end
			// Frame averaging
			cur = in_xy;
			m_stb = 1'b0;
			if (sync) begin
				m_seen = 1'b1;
				m_phase = 1;
				m_sum_i = iq ? cur : 0;
				m_sum_q = iq ? 0 : cur;
			end else if (m_seen) begin
				m_phase++;
				if (iq)
					m_sum_i += cur;
				else
					m_sum_q += cur;
				if (m_phase == `FDBK_FRAME) begin
					// Four samples per axis, floor of the mean
					m_stb = 1'b1;
					m_avg_i = m_sum_i >>> 2;
					m_avg_q = m_sum_q >>> 2;
				end
			end
			m_prop = prop_ref(iq ? settings.set_x : settings.set_y, cur, settings.gain_p,
				coarse_scale);
			m_prop_iq = iq;
		end
	end

	// Outputs are compared mid-cycle, away from the edge
	always @(negedge clk) begin
		check_cnt++;
		if (out_xy !== sample_t'(m_out)) begin
			err_cnt++;
			$display("ERROR @%0t: out_xy is %0d, expected %0d", $time, out_xy, sample_t'(m_out));
		end
		if (out_iq !== m_out_iq) begin
			err_cnt++;
			$display("ERROR @%0t: out_iq is %b, expected %b", $time, out_iq, m_out_iq);
		end
		if (cmp_event !== m_ev) begin
			err_cnt++;
			$display("ERROR @%0t: cmp_event is %b, expected %b", $time, cmp_event, m_ev);
		end
	end

endmodule

`default_nettype wire

// File: dv/fdbk_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module fdbk_core_props (
	input wire clk,
	input wire arst_n,
	input wire sync,
	input wire iq,
	input wire avg_stb,
	input wire fdbk_pkg::cmp_event_t cmp_event
);

	// Cycles since the last sync, saturating
	logic [3:0] gap;
	logic seen;
	// Eighth sample of a frame, delayed by one cycle
	logic end_d;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gap <= '0;
			seen <= 1'b0;
			end_d <= 1'b0;
		end else begin
			end_d <= seen && !sync && (gap == 4'd7);
			if (sync) begin
				seen <= 1'b1;
				gap <= 4'd1;
			end else if (gap != 4'hf) begin
				gap <= gap + 4'd1;
			end
		end
	end

	// Frame starts on an I sample
	a_sync_on_i: assert property (@(posedge clk) disable iff (!arst_n) sync |-> iq)
		else $error("sync seen on a Q sample");

	// Exactly eight cycles between syncs
	a_sync_gap: assert property (@(posedge clk) disable iff (!arst_n)
		seen |-> (sync == (gap == 4'd8)))
		else $error("sync spacing is not eight cycles");

	// Strobe right after the eighth sample and nowhere else
	a_stb_timing: assert property (@(posedge clk) disable iff (!arst_n) avg_stb == end_d)
		else $error("avg_stb not one cycle after frame end");

	a_x_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(cmp_event.x_hi && cmp_event.x_lo))
		else $error("x_hi and x_lo high together");

	a_y_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(cmp_event.y_hi && cmp_event.y_lo))
		else $error("y_hi and y_lo high together");

endmodule

`default_nettype wire

// File: dv/fdbk_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fdbk_config.svh"

module fdbk_core_tb;

	import fdbk_pkg::*;

	localparam sample_t SAT_MAX = {1'b0, {(`FDBK_SAMPLE_W-1){1'b1}}};
	localparam sample_t SAT_MIN = {1'b1, {(`FDBK_SAMPLE_W-1){1'b0}}};
	localparam cmp_event_t EV_X_HI = '{x_hi: 1'b1, default: 1'b0};
	localparam cmp_event_t EV_X_LO = '{x_lo: 1'b1, default: 1'b0};
	localparam cmp_event_t EV_Y_HI = '{y_hi: 1'b1, default: 1'b0};
	localparam cmp_event_t EV_Y_LO = '{y_lo: 1'b1, default: 1'b0};

	// Clock starts low with no edge at time zero
	logic clk = 1'b0;
	logic arst_n;
	logic sync;
	logic iq;
	sample_t in_xy;
	fdbk_settings_t settings;
	shift_t coarse_scale;
	sample_t out_xy;
	logic out_iq;
	cmp_event_t cmp_event;
	int err_cnt;
	int check_cnt;
	int tb_errs;
	int seed;
	int phase;
	int pulses;
	logic hit_max;
	logic hit_min;

	always #4 clk = ~clk;

	fdbk_core dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.sync         (sync),
		.iq           (iq),
		.in_xy        (in_xy),
		.settings     (settings),
		.coarse_scale (coarse_scale),
		.out_xy       (out_xy),
		.out_iq       (out_iq),
		.cmp_event    (cmp_event)
	);

	fdbk_checker chk (
		.clk          (clk),
		.arst_n       (arst_n),
		.sync         (sync),
		.iq           (iq),
		.in_xy        (in_xy),
		.settings     (settings),
		.coarse_scale (coarse_scale),
		.out_xy       (out_xy),
		.out_iq       (out_iq),
		.cmp_event    (cmp_event),
		.err_cnt      (err_cnt),
		.check_cnt    (check_cnt)
	);

	bind fdbk_core fdbk_core_props u_props (
		.clk       (clk),
		.arst_n    (arst_n),
		.sync      (sync),
		.iq        (iq),
		.avg_stb   (avg_stb),
		.cmp_event (cmp_event)
	);

	function automatic sample_t rand_sample();
		return sample_t'($random(seed));
	endfunction

	// One sample per cycle with I first and sync on the first I of each frame
	task automatic drive_sample(input sample_t i_val, input sample_t q_val);
		@(posedge clk);
		#1;
		sync = (phase == 0);
		iq = !phase[0];
		in_xy = phase[0] ? q_val : i_val;
		phase = (phase + 1) % `FDBK_FRAME;
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (10) drive_sample('0, '0);
		arst_n = 1'b1;
	endtask

	task automatic wait_strobes(input int count, input int max_cycles, input sample_t i_val,
		input sample_t q_val);
		int seen_cnt;
		int n;
		seen_cnt = 0;
		n = 0;
		while (seen_cnt < count && n < max_cycles) begin
			drive_sample(i_val, q_val);
			if (dut.u_decim.avg_stb)
				seen_cnt++;
			n++;
		end
		if (seen_cnt < count) begin
			tb_errs++;
			$display("Timeout: %0d of %0d frame strobes in %0d cycles", seen_cnt, count, n);
		end
	endtask

	task automatic wait_event(input cmp_event_t mask, input int max_cycles, input string what);
		int n;
		n = 0;
		while ((cmp_event & mask) == 4'b0 && n < max_cycles) begin
			drive_sample('0, '0);
			n++;
		end
		if ((cmp_event & mask) == 4'b0) begin
			tb_errs++;
			$display("Timeout: no %s clamp event within %0d cycles", what, max_cycles);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		sync = 1'b0;
		iq = 1'b0;
		in_xy = '0;
		settings = '0;
		coarse_scale = '0;
		tb_errs = 0;
		seed = 68923;
		phase = 0;
		hit_max = 1'b0;
		hit_min = 1'b0;

		// Reset values and then idle with zero settings
		apply_reset();
		repeat (16) drive_sample('0, '0);

		// Proportional path alone over every coarse scale
		settings.lim_hi = SAT_MAX;
		settings.lim_lo = SAT_MIN;
		settings.set_x = rand_sample();
		settings.set_y = rand_sample();
		for (int cs = 0; cs < 4; cs++) begin
			coarse_scale = shift_t'(cs);
			settings.gain_p = gain_t'($random(seed));
			repeat (64) drive_sample(rand_sample(), rand_sample());
		end

		// Integral path alone with a constant input
		apply_reset();
		coarse_scale = '0;
		settings = '0;
		settings.set_x = 18'sd20000;
		settings.set_y = -18'sd10000;
		settings.gain_i = 16'sh2000;
		settings.lim_hi = 18'sd100000;
		settings.lim_lo = -18'sd100000;
		wait_strobes(6, 80, 18'sd1000, -18'sd2000);
		repeat (4) drive_sample(18'sd1000, -18'sd2000);
		if (out_xy == '0) begin
			tb_errs++;
			$display("ERROR @%0t: out_xy still zero after six integral updates", $time);
		end

		// Large error against narrow limits
		apply_reset();
		settings.set_x = 18'sd60000;
		settings.set_y = -18'sd60000;
		settings.gain_i = 16'sh7fff;
		settings.lim_hi = 18'sd500;
		settings.lim_lo = -18'sd300;
		wait_event(EV_X_HI, 40, "x_hi");
		wait_event(EV_Y_LO, 40, "y_lo");
		// One clamped update per frame
		pulses = 0;
		repeat (48) begin
			drive_sample('0, '0);
			if (cmp_event.x_hi)
				pulses++;
		end
		if (pulses != 48 / `FDBK_FRAME) begin
			tb_errs++;
			$display("ERROR @%0t: %0d x_hi pulses over six frames, expected %0d",
				$time, pulses, 48 / `FDBK_FRAME);
		end
		settings.set_x = -18'sd60000;
		settings.set_y = 18'sd60000;
		wait_event(EV_X_LO, 40, "x_lo");
		wait_event(EV_Y_HI, 40, "y_hi");

		// Both paths with random full-scale input
		apply_reset();
		settings.set_x = rand_sample();
		settings.set_y = rand_sample();
		settings.gain_i = 16'sh4000;
		settings.gain_p = 16'sh7fff;
		settings.lim_hi = SAT_MAX;
		settings.lim_lo = SAT_MIN;
		repeat (400) begin
			drive_sample(rand_sample(), rand_sample());
			hit_max |= (out_xy == SAT_MAX);
			hit_min |= (out_xy == SAT_MIN);
		end
		if (!hit_max || !hit_min) begin
			tb_errs++;
			$display("Output never reached both full-scale limits");
		end
		repeat (4) drive_sample('0, '0);

		$display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
			check_cnt, err_cnt, tb_errs);
		if (err_cnt == 0 && tb_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: fdbk_core.f
+incdir+design
design/fdbk_pkg.sv
design/frame_decim.sv
design/integ_ctrl.sv
design/prop_ctrl.sv
design/drive_combine.sv
design/fdbk_core.sv
dv/fdbk_core_props.sv
dv/fdbk_checker.sv
dv/fdbk_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the feedback core testbench with Verilator and run it

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fdbk_core_tb -f fdbk_core.f -o fdbk_sim \
	&& ./obj_dir/fdbk_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log \
	&& { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation PASSED"; exit 0; }
